// File: dv/ex_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu_tb;
    import alu_op_pkg::*;
    import ex_types_pkg::*;

    typedef struct packed {
        int              op;
        logic            word;
        sext_t           sext;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        int              ready_low;
        logic [xlen-1:0] exp;
    } vec_t;

    localparam logic [xlen-1:0] ones  = {xlen{1'b1}};
    localparam logic [xlen-1:0] s_min = {1'b1, {(xlen-1){1'b0}}};
    localparam logic [xlen-1:0] s_max = {1'b0, {(xlen-1){1'b1}}};

    logic            I_sys_clk;
    logic            I_rst;
    alu_req_t        req;
    logic            alu_valid;
    logic            ex_mem_ready;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] result;
    logic            result_valid;
    vec_t            vecs[$];
    int              n_tests = 0;

    ex_alu i_ex_alu (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .req          (req),
        .alu_valid    (alu_valid),
        .ex_mem_ready (ex_mem_ready),
        .mem_addr     (mem_addr),
        .result       (result),
        .result_valid (result_valid)
    );

    initial I_sys_clk = 1'b0;
    always #2 I_sys_clk = ~I_sys_clk;

    function automatic void add_vec(input int op, input logic word, input sext_t sext,
                                    input logic [xlen-1:0] op1, input logic [xlen-1:0] op2,
                                    input int ready_low, input logic [xlen-1:0] exp);
        vecs.push_back('{op, word, sext, op1, op2, ready_low, exp});
    endfunction

    // cycles from the alu_valid edge to result_valid
    function automatic int latency_of(input int op);
        if (op == op_mul || op == op_mulh) return 65;
        if (op == op_div || op == op_rem) return 66;
        return 0;
    endfunction

    task automatic check_equal(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////
    initial begin
        wait (n_tests > 0);
        repeat (n_tests * 80 + 10) @(posedge I_sys_clk);
        $display("watchdog expired, the run timed out waiting for a result");
        $display("tests failed");
        $fatal(1);
    end

    initial begin : main_seq
        vec_t            v;
        int              cycles;
        int              lat;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        I_rst        = 1'b1;
        req          = '0;
        alu_valid    = 1'b0;
        ex_mem_ready = 1'b1;
        a = xlen'($urandom(82));

        // single-cycle ops and compare edges
        add_vec(op_add,  0, 2'b00, 64'd5, 64'd7, 0, 64'd12);
        add_vec(op_sub,  0, 2'b00, 64'd3, 64'd5, 0, 64'hFFFF_FFFF_FFFF_FFFE);
        add_vec(op_slt,  0, 2'b00, s_min, s_max, 0, 64'd1);
        add_vec(op_slt,  0, 2'b00, s_max, s_min, 0, 64'd0);
        add_vec(op_sltu, 0, 2'b00, s_min, s_max, 0, 64'd0);
        add_vec(op_sltu, 0, 2'b00, 64'd1, ones,  0, 64'd1);
        add_vec(op_xor,  0, 2'b00, 64'hF0F0, 64'hFF00, 0, 64'h0FF0);
        add_vec(op_or,   0, 2'b00, 64'hF0F0, 64'h0F0F, 0, 64'hFFFF);
        add_vec(op_and,  0, 2'b00, 64'hF0F0, 64'hFF00, 0, 64'hF000);
        add_vec(op_add,  1, 2'b00, 64'h7FFF_FFFF, 64'd1, 0, 64'hFFFF_FFFF_8000_0000);
        // doubleword shifts first, word shifts after
        add_vec(op_sll, 0, 2'b00, 64'd1, 64'd63, 0, s_min);
        add_vec(op_srl, 0, 2'b00, s_min, 64'd63, 0, 64'd1);
        add_vec(op_sra, 0, 2'b00, s_min, 64'd63, 0, ones);
        add_vec(op_sra, 0, 2'b00, 64'h8000_0000_0000_0001, 64'd0, 0, 64'h8000_0000_0000_0001);
        add_vec(op_sll, 0, 2'b00, 64'd1, 64'd31, 0, 64'h0000_0000_8000_0000);
        add_vec(op_srl, 0, 2'b00, s_min, 64'd31, 0, 64'h0000_0001_0000_0000);
        add_vec(op_sra, 0, 2'b00, s_min, 64'd31, 0, 64'hFFFF_FFFF_0000_0000);
        add_vec(op_sll, 0, 2'b00, 64'h1234_5678_9ABC_DEF0, 64'd0, 0, 64'h1234_5678_9ABC_DEF0);
        add_vec(op_srl, 0, 2'b00, s_min, 64'd0, 0, s_min);
        add_vec(op_sll, 1, 2'b00, 64'd1, 64'd31, 0, 64'hFFFF_FFFF_8000_0000);
        add_vec(op_sll, 1, 2'b00, 64'h1234_5678_9ABC_DEF0, 64'd0, 0, 64'hFFFF_FFFF_9ABC_DEF0);
        add_vec(op_srl, 1, 2'b00, 64'hFFFF_FFFF_8000_0000, 64'd31, 0, 64'd1);
        add_vec(op_srl, 1, 2'b00, 64'h8000_0000, 64'd0, 0, 64'hFFFF_FFFF_8000_0000);
        add_vec(op_sra, 1, 2'b00, 64'h8000_0000, 64'd31, 0, ones);
        // word forms only use the low five bits of the amount
        add_vec(op_sll, 1, 2'b00, 64'd1, 64'd63, 0, 64'hFFFF_FFFF_8000_0000);
        add_vec(op_srl, 1, 2'b00, 64'h8000_0000, 64'd63, 0, 64'd1);
        add_vec(op_sra, 1, 2'b00, 64'h8000_0000, 64'd63, 0, ones);
        add_vec(op_sra, 1, 2'b00, 64'h8000_0000, 64'd0, 0, 64'hFFFF_FFFF_8000_0000);
        // multiply, mulh forms and mulw
        add_vec(op_mul,  0, 2'b11, 64'd6, 64'd7, 0, 64'd42);
        add_vec(op_mul,  0, 2'b11, -64'sd3, -64'sd5, 0, 64'd15);
        add_vec(op_mulh, 0, 2'b11, -64'sd3, -64'sd5, 0, 64'd0);
        add_vec(op_mulh, 0, 2'b11, s_min, s_min, 0, 64'h4000_0000_0000_0000);
        add_vec(op_mulh, 0, 2'b00, ones, ones, 0, 64'hFFFF_FFFF_FFFF_FFFE);
        add_vec(op_mulh, 0, 2'b10, ones, ones, 0, ones);
        add_vec(op_mul,  1, 2'b11, 64'h7FFF_FFFF, 64'd2, 0, 64'hFFFF_FFFF_FFFF_FFFE);
        add_vec(op_mulh, 0, 2'b00, ones, ones, 5, 64'hFFFF_FFFF_FFFF_FFFE);
        // divide, remainder and corner cases
        add_vec(op_div, 0, 2'b11, -64'sd7, 64'd2, 0, 64'hFFFF_FFFF_FFFF_FFFD);
        add_vec(op_rem, 0, 2'b11, -64'sd7, 64'd2, 0, ones);
        add_vec(op_div, 0, 2'b00, 64'd100, 64'd7, 3, 64'd14);
        add_vec(op_rem, 0, 2'b00, 64'd100, 64'd7, 0, 64'd2);
        add_vec(op_div, 0, 2'b11, 64'd5, 64'd0, 0, ones);
        add_vec(op_rem, 0, 2'b11, 64'd5, 64'd0, 0, 64'd5);
        add_vec(op_div, 0, 2'b00, 64'd5, 64'd0, 0, ones);
        add_vec(op_div, 0, 2'b11, s_min, ones, 0, s_min);
        add_vec(op_rem, 0, 2'b11, s_min, ones, 10, 64'd0);
        add_vec(op_div, 1, 2'b11, 64'hFFFF_FFF9, 64'd2, 0, 64'hFFFF_FFFF_FFFF_FFFD);
        add_vec(op_div, 1, 2'b00, 64'hFFFF_FFFF, 64'd1, 0, 64'h0000_0000_FFFF_FFFF);
        add_vec(op_rem, 1, 2'b00, 64'h8000_0005, 64'h8000_0006, 0, 64'h0000_0000_8000_0005);

        // random operands for add, xor, sll and mul
        for (int i = 0; i < 8; i++) begin
            a = {$urandom(), $urandom()};
            b = {$urandom(), $urandom()};
            case (i % 4)
                0:       add_vec(op_add, 0, 2'b00, a, b, 0, a + b);
                1:       add_vec(op_xor, 0, 2'b00, a, b, 0, a ^ b);
                2:       add_vec(op_sll, 0, 2'b00, a, b, 0, a << b[5:0]);
                default: add_vec(op_mul, 0, 2'b11, a, b, 0, a * b);
            endcase
        end
        n_tests = vecs.size();

        repeat (5) @(posedge I_sys_clk);
        #0.5 I_rst = 1'b0;
        @(posedge I_sys_clk);
        #0.5;

        //////////////////////////////////////////////////
        // apply each entry
        //////////////////////////////////////////////////
        for (int i = 0; i < n_tests; i++) begin
            v   = vecs[i];
            lat = latency_of(v.op);
            req.op1       = v.op1;
            req.op2       = v.op2;
            req.op_sel    = '0;
            req.op_sel[v.op] = 1'b1;
            req.sext      = v.sext;
            req.word      = v.word;
            alu_valid     = 1'b1;
            ex_mem_ready  = (v.ready_low == 0);
            cycles        = 0;
            #1;
            check_equal(mem_addr, v.op1 + v.op2, $sformatf("vec %0d mem_addr", i));
            while (result_valid !== 1'b1) begin
                @(posedge I_sys_clk);
                #1;
                cycles++;
            end
            check_equal(64'(cycles), 64'(lat), $sformatf("vec %0d latency", i));
            check_equal(result, v.exp, $sformatf("vec %0d result", i));

            // back-pressure keeps the result in place
            repeat (v.ready_low) begin
                @(posedge I_sys_clk);
                #1;
                check_equal(64'(result_valid), 64'd1, $sformatf("vec %0d held valid", i));
                check_equal(result, v.exp, $sformatf("vec %0d held result", i));
            end
            if (v.ready_low != 0) begin
                @(posedge I_sys_clk);
                #0.5 ex_mem_ready = 1'b1;
                #0.5;
                check_equal(64'(result_valid), 64'd1, $sformatf("vec %0d accept valid", i));
            end
            if (lat != 0) begin
                @(posedge I_sys_clk);
                #1;
                check_equal(64'(result_valid), 64'd0, $sformatf("vec %0d valid drop", i));
            end

            @(posedge I_sys_clk);
            #0.5 alu_valid = 1'b0;
            @(posedge I_sys_clk);
            #0.5;
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/alu_op_pkg.sv
`default_nettype none

package alu_op_pkg;

    //////////////////////////////////////////////////
    // one-hot operation select
    //////////////////////////////////////////////////
    localparam int op_w    = 14;
    localparam int op_add  = 0;
    localparam int op_sub  = 1;
    localparam int op_slt  = 2;
    localparam int op_sltu = 3;
    localparam int op_xor  = 4;
    localparam int op_or   = 5;
    localparam int op_and  = 6;
    localparam int op_sll  = 7;
    localparam int op_srl  = 8;
    localparam int op_sra  = 9;
    localparam int op_mul  = 10;
    localparam int op_mulh = 11;
    localparam int op_div  = 12;
    localparam int op_rem  = 13;

    typedef logic [op_w-1:0] op_sel_t;

    // sign control, both clear on div/rem means divu/remu
    localparam int sext_op1 = 1;
    localparam int sext_op2 = 0;

    typedef logic [1:0] sext_t;

    //////////////////////////////////////////////////
    // data width and word form
    //////////////////////////////////////////////////
    localparam int xlen       = 64;
    localparam int word_w     = 32;
    localparam int shamt_w    = 6;
    localparam int shamt_w_wd = 5;

endpackage

`default_nettype wire

// File: rtl/booth_mul_serial.sv
`timescale 1ns/1ps
`default_nettype none

module booth_mul_serial (
    input  logic                    I_sys_clk,
    input  logic                    I_rst,
    input  logic                    mul_start,
    input  ex_types_pkg::md_start_t operands,
    output logic                    mul_done,
    output ex_types_pkg::mul_res_t  product
);
    import alu_op_pkg::*;
    import ex_types_pkg::*;

    // one recode step on {A, Q, q_prev}
    // A gets a guard bit for the add so nothing wraps
    function automatic logic [2*md_w:0] booth_step(input logic [2*md_w:0] st,
                                                   input logic [md_w-1:0] m);
        logic [md_w:0] a_ext;
        logic [md_w:0] m_ext;
        logic [md_w:0] sum;
        a_ext = {st[2*md_w], st[2*md_w:md_w+1]};
        m_ext = {m[md_w-1], m};
        case (st[1:0])
            2'b01:   sum = a_ext + m_ext;
            2'b10:   sum = a_ext - m_ext;
            default: sum = a_ext;
        endcase
        // arithmetic shift right drops the old q_prev
        return {sum, st[md_w:1]};
    endfunction

    logic                busy;
    logic [md_cnt_w-1:0] cnt;
    logic [md_w-1:0]     mcand;
    // 130-bit accumulator plus the booth history bit
    logic [2*md_w:0]     acc;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                busy <= 1'b1;
                cnt  <= md_cnt_w'(1);
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == md_cnt_w'(md_iter - 1)) begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // first step is taken as the operands load
    always_ff @(posedge I_sys_clk) begin
        if (mul_start) begin
            mcand <= operands.op1;
            acc   <= booth_step({{md_w{1'b0}}, operands.op2, 1'b0}, operands.op1);
        end else if (busy) begin
            acc <= booth_step(acc, mcand);
        end
    end

    // low 128 bits of {A, Q}
    assign product.hi = acc[2*xlen:xlen+1];
    assign product.lo = acc[xlen:1];

    // top level must not issue a second multiply early
    a_mul_no_overlap: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        mul_start |-> !busy);

endmodule

`default_nettype wire

// File: rtl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  logic                        I_sys_clk,
    input  logic                        I_rst,
    input  ex_types_pkg::alu_req_t      req,
    input  logic                        alu_valid,
    input  logic                        ex_mem_ready,
    output logic [alu_op_pkg::xlen-1:0] mem_addr,
    output logic [alu_op_pkg::xlen-1:0] result,
    output logic                        result_valid
);
    import alu_op_pkg::*;
    import ex_types_pkg::*;

    md_start_t       md_ops;
    logic            sign1;
    logic            sign2;
    logic            ext1;
    logic            ext2;
    logic            valid_q;
    logic            mul_class;
    logic            div_class;
    logic            mul_start;
    logic            div_start;
    logic            mul_done;
    logic            div_done;
    mul_res_t        product;
    div_res_t        quot_rem;
    logic            mul_hold;
    logic            div_hold;
    mul_res_t        mul_hold_val;
    div_res_t        div_hold_val;
    mul_res_t        mul_sel;
    div_res_t        div_sel;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] dword_res;
    logic            word_zext;
    logic            word_sign;

    //////////////////////////////////////////////////
    // operand extension to 65 bits
    //////////////////////////////////////////////////
    assign sign1 = req.word ? req.op1[word_w-1] : req.op1[xlen-1];
    assign sign2 = req.word ? req.op2[word_w-1] : req.op2[xlen-1];
    assign ext1  = req.sext[sext_op1] & sign1;
    assign ext2  = req.sext[sext_op2] & sign2;

    assign md_ops.op1 = {ext1, (req.word ? {{(xlen-word_w){ext1}}, req.op1[word_w-1:0]}
                                         : req.op1)};
    assign md_ops.op2 = {ext2, (req.word ? {{(xlen-word_w){ext2}}, req.op2[word_w-1:0]}
                                         : req.op2)};
    assign md_ops.is_signed = req.sext[sext_op1];

    // start on the rising edge of alu_valid
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= alu_valid;
        end
    end

    assign mul_class = req.op_sel[op_mul] | req.op_sel[op_mulh];
    assign div_class = req.op_sel[op_div] | req.op_sel[op_rem];
    assign mul_start = alu_valid & ~valid_q & mul_class;
    assign div_start = alu_valid & ~valid_q & div_class;

    int_alu i_int_alu (
        .req      (req),
        .alu_out  (alu_out),
        .addr_sum (mem_addr)
    );

    booth_mul_serial i_booth_mul_serial (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .mul_start (mul_start),
        .operands  (md_ops),
        .mul_done  (mul_done),
        .product   (product)
    );

    radix2_div i_radix2_div (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .div_start (div_start),
        .operands  (md_ops),
        .div_done  (div_done),
        .quot_rem  (quot_rem)
    );

    //////////////////////////////////////////////////
    // hold a finished result under back-pressure
    //////////////////////////////////////////////////
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mul_hold <= 1'b0;
            div_hold <= 1'b0;
        end else begin
            if (mul_done && !ex_mem_ready) begin
                mul_hold <= 1'b1;
            end else if (ex_mem_ready) begin
                mul_hold <= 1'b0;
            end
            if (div_done && !ex_mem_ready) begin
                div_hold <= 1'b1;
            end else if (ex_mem_ready) begin
                div_hold <= 1'b0;
            end
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (mul_done && !ex_mem_ready) begin
            mul_hold_val <= product;
        end
        if (div_done && !ex_mem_ready) begin
            div_hold_val <= quot_rem;
        end
    end

    assign mul_sel = mul_hold ? mul_hold_val : product;
    assign div_sel = div_hold ? div_hold_val : quot_rem;

    // final select
    assign dword_res = alu_out
                     | ({xlen{req.op_sel[op_mul]}}  & mul_sel.lo)
                     | ({xlen{req.op_sel[op_mulh]}} & mul_sel.hi)
                     | ({xlen{req.op_sel[op_div]}}  & div_sel.quot)
                     | ({xlen{req.op_sel[op_rem]}}  & div_sel.rem);

    // only divuw and remuw zero-extend
    assign word_zext = div_class & ~|req.sext;
    assign word_sign = ~word_zext & dword_res[word_w-1];
    assign result    = req.word ? {{(xlen-word_w){word_sign}}, dword_res[word_w-1:0]}
                                : dword_res;

    assign result_valid = mul_class ? (mul_done | mul_hold)
                        : div_class ? (div_done | div_hold)
                        : 1'b1;

    // held results survive until the next stage takes them
    a_mul_hold_stable: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        mul_hold && !ex_mem_ready |=> mul_hold && $stable(mul_hold_val));
    a_div_hold_stable: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        div_hold && !ex_mem_ready |=> div_hold && $stable(div_hold_val));

endmodule

`default_nettype wire

// File: rtl/ex_types_pkg.sv
`default_nettype none

package ex_types_pkg;

    // multicycle operands carry one extra sign bit
    localparam int md_w     = alu_op_pkg::xlen + 1;
    localparam int md_iter  = md_w;
    localparam int md_cnt_w = $clog2(md_iter + 1);

    // request held by the issue stage
    typedef struct packed {
        logic [alu_op_pkg::xlen-1:0] op1;
        logic [alu_op_pkg::xlen-1:0] op2;
        alu_op_pkg::op_sel_t         op_sel;
        alu_op_pkg::sext_t           sext;
        logic                        word;
    } alu_req_t;

    // start payload for mul and div
    typedef struct packed {
        logic [md_w-1:0] op1;
        logic [md_w-1:0] op2;
        logic            is_signed;
    } md_start_t;

    typedef struct packed {
        logic [alu_op_pkg::xlen-1:0] hi;
        logic [alu_op_pkg::xlen-1:0] lo;
    } mul_res_t;

    typedef struct packed {
        logic [alu_op_pkg::xlen-1:0] quot;
        logic [alu_op_pkg::xlen-1:0] rem;
    } div_res_t;

endpackage

`default_nettype wire

// File: rtl/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  ex_types_pkg::alu_req_t      req,
    output logic [alu_op_pkg::xlen-1:0] alu_out,
    output logic [alu_op_pkg::xlen-1:0] addr_sum
);
    import alu_op_pkg::*;

    function automatic logic [xlen-1:0] bit_rev(input logic [xlen-1:0] x);
        logic [xlen-1:0] r;
        for (int i = 0; i < xlen; i++) begin
            r[i] = x[xlen-1-i];
        end
        return r;
    endfunction

    logic               use_sub;
    logic [xlen-1:0]    add_b;
    logic [xlen-1:0]    sum;
    logic               carry;
    logic               lt_s;
    logic               lt_u;
    logic               sh_left;
    logic [shamt_w-1:0] shamt;
    logic [xlen-1:0]    sh_src;
    logic [word_w-1:0]  sh_src_w;
    logic [xlen-1:0]    sh_in;
    logic [xlen-1:0]    sh_out;
    logic [xlen-1:0]    sll_rev;
    logic [xlen-1:0]    sll_res;
    logic               sh_sign;
    logic [xlen-1:0]    sra_mask;
    logic [xlen-1:0]    sra_res;

    //////////////////////////////////////////////////
    // shared adder for add, sub and compares
    //////////////////////////////////////////////////
    assign use_sub = req.op_sel[op_sub] | req.op_sel[op_slt] | req.op_sel[op_sltu];
    assign add_b   = use_sub ? ~req.op2 : req.op2;
    assign {carry, sum} = {1'b0, req.op1} + {1'b0, add_b} + {{xlen{1'b0}}, use_sub};

    // signs differ decides directly, else the difference sign
    assign lt_s = (req.op1[xlen-1] & ~req.op2[xlen-1])
                | (~(req.op1[xlen-1] ^ req.op2[xlen-1]) & sum[xlen-1]);
    // no carry out means borrow
    assign lt_u = ~carry;

    // load/store address
    assign addr_sum = req.op1 + req.op2;

    //////////////////////////////////////////////////
    // one right shifter for all shifts
    //////////////////////////////////////////////////
    assign sh_left  = req.op_sel[op_sll];
    assign shamt    = req.word ? {1'b0, req.op2[shamt_w_wd-1:0]} : req.op2[shamt_w-1:0];
    assign sh_src   = sh_left ? bit_rev(req.op1) : req.op1;
    // reversed low word ends up in the upper half
    assign sh_src_w = sh_left ? sh_src[xlen-1:word_w] : sh_src[word_w-1:0];
    assign sh_in    = req.word ? {{(xlen-word_w){1'b0}}, sh_src_w} : sh_src;
    assign sh_out   = sh_in >> shamt;

    // undo the reversal for sll
    assign sll_rev = bit_rev(sh_out);
    assign sll_res = req.word ? {{(xlen-word_w){1'b0}}, sll_rev[xlen-1:word_w]} : sll_rev;

    // fill vacated bits with the sign for sra
    assign sh_sign  = req.word ? req.op1[word_w-1] : req.op1[xlen-1];
    assign sra_mask = req.word ? ~({{(xlen-word_w){1'b0}}, {word_w{1'b1}}} >> shamt)
                               : ~({xlen{1'b1}} >> shamt);
    assign sra_res  = ({xlen{sh_sign}} & sra_mask) | sh_out;

    // mul/div class selects nothing here
    assign alu_out = ({xlen{req.op_sel[op_add] | req.op_sel[op_sub]}} & sum)
                   | ({xlen{req.op_sel[op_slt]}}  & {{(xlen-1){1'b0}}, lt_s})
                   | ({xlen{req.op_sel[op_sltu]}} & {{(xlen-1){1'b0}}, lt_u})
                   | ({xlen{req.op_sel[op_xor]}}  & (req.op1 ^ req.op2))
                   | ({xlen{req.op_sel[op_or]}}   & (req.op1 | req.op2))
                   | ({xlen{req.op_sel[op_and]}}  & (req.op1 & req.op2))
                   | ({xlen{req.op_sel[op_sll]}}  & sll_res)
                   | ({xlen{req.op_sel[op_srl]}}  & sh_out)
                   | ({xlen{req.op_sel[op_sra]}}  & sra_res);

endmodule

`default_nettype wire

// File: rtl/radix2_div.sv
`timescale 1ns/1ps
`default_nettype none

module radix2_div (
    input  logic                    I_sys_clk,
    input  logic                    I_rst,
    input  logic                    div_start,
    input  ex_types_pkg::md_start_t operands,
    output logic                    div_done,
    output ex_types_pkg::div_res_t  quot_rem
);
    import alu_op_pkg::*;
    import ex_types_pkg::*;

    // shift in the next dividend bit and try the subtract
    function automatic logic [2*md_w-1:0] div_step(input logic [md_w-1:0] r,
                                                   input logic [md_w-1:0] q,
                                                   input logic [md_w-1:0] d);
        logic [md_w:0]     sh;
        logic [md_w+1:0]   trial;
        logic [2*md_w-1:0] res;
        sh    = {r, q[md_w-1]};
        trial = {1'b0, sh} - {2'b00, d};
        if (trial[md_w+1]) begin
            res = {sh[md_w-1:0], q[md_w-2:0], 1'b0};
        end else begin
            res = {trial[md_w-1:0], q[md_w-2:0], 1'b1};
        end
        return res;
    endfunction

    logic [md_w-1:0]     dvd_abs;
    logic [md_w-1:0]     dvs_abs;
    logic [md_w-1:0]     part_rem;
    logic [md_w-1:0]     quo;
    logic [md_w-1:0]     dvsr;
    logic [xlen-1:0]     dvd_raw;
    logic                neg_quo;
    logic                neg_rem;
    logic                by_zero;
    logic                ovf;
    logic                busy;
    logic [md_cnt_w-1:0] cnt;

    // magnitudes for the signed forms
    assign dvd_abs = (operands.is_signed & operands.op1[md_w-1]) ? -operands.op1 : operands.op1;
    assign dvs_abs = (operands.is_signed & operands.op2[md_w-1]) ? -operands.op2 : operands.op2;

    //////////////////////////////////////////////////
    // control, 65 steps then one fix-up cycle
    //////////////////////////////////////////////////
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy <= 1'b1;
                cnt  <= md_cnt_w'(1);
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == md_cnt_w'(md_iter)) begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (div_start) begin
            {part_rem, quo} <= div_step('0, dvd_abs, dvs_abs);
            dvsr    <= dvs_abs;
            dvd_raw <= operands.op1[xlen-1:0];
            neg_quo <= operands.is_signed & (operands.op1[md_w-1] ^ operands.op2[md_w-1]);
            neg_rem <= operands.is_signed & operands.op1[md_w-1];
            by_zero <= ~|operands.op2;
            ovf     <= operands.is_signed & (&operands.op2)
                     & (operands.op1 == {2'b11, {(xlen-1){1'b0}}});
        end else if (busy && cnt != md_cnt_w'(md_iter)) begin
            {part_rem, quo} <= div_step(part_rem, quo, dvsr);
        end else if (busy) begin
            // sign fix-up and RISC-V corner cases
            if (by_zero) begin
                quot_rem.quot <= '1;
                quot_rem.rem  <= dvd_raw;
            end else if (ovf) begin
                quot_rem.quot <= dvd_raw;
                quot_rem.rem  <= '0;
            end else begin
                quot_rem.quot <= neg_quo ? -quo[xlen-1:0] : quo[xlen-1:0];
                quot_rem.rem  <= neg_rem ? -part_rem[xlen-1:0] : part_rem[xlen-1:0];
            end
        end
    end

    // top level must not issue a second divide early
    a_div_no_overlap: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        div_start |-> !busy);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line
rm -rf obj_dir
verilator --binary --timing --assert --top-module ex_alu_tb -f verilog.f -o ex_alu_sim \
    && ./obj_dir/ex_alu_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see sim.log"; exit 1; }
grep -qx "all tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: verilog.f
rtl/alu_op_pkg.sv
rtl/ex_types_pkg.sv
rtl/int_alu.sv
rtl/booth_mul_serial.sv
rtl/radix2_div.sv
rtl/ex_alu.sv
dv/ex_alu_tb.sv
